/* src/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// ----------------------------------------
// uart sizing
// ----------------------------------------

// width of a serial data byte and of the host data path
`define UART_DATA_WIDTH 8

// receive fifo entries, keep a power of two
`define UART_FIFO_DEPTH 16

// ----------------------------------------
// reset configuration
// ----------------------------------------

`define UART_RESET_DIVISOR    10416 // 100 MHz / 9600 baud
`define UART_RESET_FRAME_BITS 8     // data bits per frame after reset

`endif

/* src/uartPkg.sv */
`default_nettype none

package uartPkg;

    // host visible register map
    typedef enum logic [2:0] {
        ADDR_TXDATA  = 3'd0,  // transmit holding byte
        ADDR_RXDATA  = 3'd1,  // read pops the receive fifo
        ADDR_STATUS  = 3'd2,  // bit 0 rxValid, bit 1 txReady
        ADDR_DIVISOR = 3'd3,  // clocks per bit
        ADDR_FRAME   = 3'd4   // bitsPerFrame, rxIre, txIre
    } regAddr;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txState;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxState;

    // host request and response payloads
    typedef struct packed {
        logic        write;
        regAddr      addr;
        logic [15:0] wdata;
    } busReq;

    typedef struct packed {
        logic [15:0] rdata;
    } busRsp;

    // serial line setup shared by both directions
    typedef struct packed {
        logic [15:0] clocksPerCycle;
        logic [3:0]  bitsPerFrame;
    } uartConfig;

endpackage

`default_nettype wire

/* src/uartFifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartFifo #(
    parameter int depth = `UART_FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        writeEn,
    input  logic [`UART_DATA_WIDTH-1:0] dataIn,
    input  logic                        readReq,
    output logic [`UART_DATA_WIDTH-1:0] dataOut,
    output logic [$clog2(depth):0]      wordCount,
    output logic                        empty
);
    localparam int ptrWidth = $clog2(depth);

    logic [`UART_DATA_WIDTH-1:0] mem [depth];
    logic [ptrWidth-1:0]         wrPtr;
    logic [ptrWidth-1:0]         rdPtr;
    logic                        full;
    logic                        doWrite;
    logic                        doRead;

    assign empty   = (wordCount == '0);
    assign full    = (wordCount == (ptrWidth+1)'(depth));
    assign doWrite = writeEn && !full;    // overflow drops the byte
    assign doRead  = readReq && !empty;
    assign dataOut = mem[rdPtr];          // head visible without a read

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= dataIn;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            wordCount <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead)  rdPtr <= rdPtr + 1'b1;
            case ({doWrite, doRead})
                2'b10:   wordCount <= wordCount + 1'b1;
                2'b01:   wordCount <= wordCount - 1'b1;
                default: wordCount <= wordCount;   // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/uartRegs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartRegs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        reqValid,
    input  uartPkg::busReq              req,
    output logic                        reqReady,
    output logic                        rspValid,
    output uartPkg::busRsp              rsp,
    input  logic                        rspReady,
    output uartPkg::uartConfig          cfg,
    output logic                        txDataValid,
    output logic [`UART_DATA_WIDTH-1:0] txByte,
    input  logic                        txTake,
    input  logic [`UART_DATA_WIDTH-1:0] fifoHead,
    input  logic                        fifoEmpty,
    output logic                        popReq,
    output logic                        txIrq,
    output logic                        rxIrq
);
    import uartPkg::*;

    logic        accept;          // request handshake this cycle
    logic        txWrite;
    logic        frameWrite;
    logic [15:0] readData;
    logic        txReady;         // holding register free for the host
    logic        rxIre;
    logic        txIre;
    logic        txIrePre;        // last cycle copies for edge detection
    logic        txDataValidPre;

    // ----------------------------------------
    // bus handshake and decode
    // ----------------------------------------

    assign reqReady   = !rspValid || rspReady; // one request in flight
    assign accept     = reqValid && reqReady;
    assign txWrite    = accept && req.write && (req.addr == ADDR_TXDATA);
    assign frameWrite = accept && req.write && (req.addr == ADDR_FRAME);
    assign popReq     = accept && !req.write && (req.addr == ADDR_RXDATA);

    always_comb begin
        case (req.addr)
            ADDR_TXDATA:  readData = 16'(txByte);
            ADDR_RXDATA:  readData = 16'(fifoHead);      // head taken with the pop
            ADDR_STATUS:  readData = {14'd0, txReady, !fifoEmpty};
            ADDR_DIVISOR: readData = cfg.clocksPerCycle;
            ADDR_FRAME:   readData = {10'd0, txIre, rxIre, cfg.bitsPerFrame};
            default:      readData = 16'd0;              // unmapped
        endcase
    end

    // response held until the host takes it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rspValid <= 1'b0;
        end else if (accept) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.rdata <= req.write ? 16'd0 : readData; // writes answer zero
        end
    end

    // ----------------------------------------
    // configuration registers
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg.clocksPerCycle <= 16'(`UART_RESET_DIVISOR);
            cfg.bitsPerFrame   <= 4'(`UART_RESET_FRAME_BITS);
            rxIre              <= 1'b0;
            txIre              <= 1'b0;
        end else begin
            if (accept && req.write && (req.addr == ADDR_DIVISOR)) begin
                cfg.clocksPerCycle <= req.wdata;
            end
            if (frameWrite) begin
                cfg.bitsPerFrame <= req.wdata[3:0];
                rxIre            <= req.wdata[4];
                txIre            <= req.wdata[5];
            end
        end
    end

    // ----------------------------------------
    // transmit holding register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (txWrite) begin
            txByte <= req.wdata[`UART_DATA_WIDTH-1:0];
        end
    end

    // a new write wins over the transmitter taking the byte
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txReady     <= 1'b1;
            txDataValid <= 1'b0;
        end else if (txWrite) begin
            txReady     <= 1'b0;
            txDataValid <= 1'b1;
        end else if (txTake) begin
            txReady     <= 1'b1; // byte moved into the shifter
            txDataValid <= 1'b0;
        end
    end

    // ----------------------------------------
    // interrupts
    // ----------------------------------------

    // tx pulse on holding register draining, or enable rising while empty
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            txIrq          <= 1'b0;
            rxIrq          <= 1'b0;
            txIrePre       <= 1'b0;
            txDataValidPre <= 1'b0;
        end else begin
            txIrq <= (!txDataValid && txIre && !txIrePre)
                   | (txIre && txDataValidPre && !txDataValid);
            rxIrq          <= rxIre && !fifoEmpty; // level while data waits
            txIrePre       <= txIre;
            txDataValidPre <= txDataValid;
        end
    end

endmodule

`default_nettype wire

/* src/uartTransmitter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartTransmitter (
    input  logic                        clk,
    input  logic                        reset,
    input  uartPkg::uartConfig          cfg,
    input  logic                        txDataValid,
    input  logic [`UART_DATA_WIDTH-1:0] txByte,
    output logic                        txTake,
    output logic                        tx
);
    import uartPkg::*;

    txState                      state;
    uartConfig                   frameCfg;  // cfg frozen for the frame
    logic [15:0]                 bitTimer;  // clocks into the current bit
    logic [3:0]                  bitIndex;  // data bit being sent
    logic [`UART_DATA_WIDTH-1:0] shiftReg;
    logic                        bitDone;

    assign txTake  = (state == TX_IDLE) && txDataValid;
    assign bitDone = (bitTimer == frameCfg.clocksPerCycle - 16'd1);

    // byte and setup latched at frame start, lsb always at bit 0
    always_ff @(posedge clk) begin
        if (txTake) begin
            shiftReg <= txByte;
            frameCfg <= cfg;
        end else if (bitDone && ((state == TX_START) || (state == TX_DATA))) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    // ----------------------------------------
    // frame sequencer
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= TX_IDLE;
            bitTimer <= '0;
            bitIndex <= '0;
            tx       <= 1'b1;           // line idles high
        end else begin
            case (state)
                TX_IDLE: begin
                    bitTimer <= '0;
                    if (txTake) begin
                        tx    <= 1'b0;  // start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        tx       <= shiftReg[0];
                        state    <= TX_DATA;
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                TX_DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        if (bitIndex == frameCfg.bitsPerFrame - 4'd1) begin
                            tx    <= 1'b1;  // stop bit
                            state <= TX_STOP;
                        end else begin
                            bitIndex <= bitIndex + 4'd1;
                            tx       <= shiftReg[0];
                        end
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                TX_STOP: begin
                    if (bitDone) begin
                        state <= TX_IDLE; // next byte may go right away
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/uartReceiver.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartReceiver (
    input  logic                        clk,
    input  logic                        reset,
    input  uartPkg::uartConfig          cfg,
    input  logic                        rx,
    output logic                        rxByteValid,
    output logic [`UART_DATA_WIDTH-1:0] rxByte
);
    import uartPkg::*;

    rxState                      state;
    uartConfig                   frameCfg;   // setup captured at the start edge
    logic [1:0]                  rxSync;     // two flop synchronizer
    logic                        rxIn;
    logic [15:0]                 bitTimer;
    logic [3:0]                  bitIndex;
    logic [`UART_DATA_WIDTH-1:0] shiftReg;   // bits enter at the top
    logic [3:0]                  alignShift;
    logic                        bitDone;
    logic                        halfDone;

    assign rxIn     = rxSync[1];
    assign bitDone  = (bitTimer == frameCfg.clocksPerCycle - 16'd1);
    assign halfDone = (bitTimer == {1'b0, frameCfg.clocksPerCycle[15:1]} - 16'd1);

    // short frames sit in the upper bits, move them down to bit 0
    assign alignShift = (frameCfg.bitsPerFrame >= 4'(`UART_DATA_WIDTH)) ? 4'd0
                      : 4'(`UART_DATA_WIDTH) - frameCfg.bitsPerFrame;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxSync <= 2'b11;
        end else begin
            rxSync <= {rxSync[0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RX_IDLE) && !rxIn) begin
            frameCfg <= cfg;
        end
        if ((state == RX_DATA) && bitDone) begin
            shiftReg <= {rxIn, shiftReg[`UART_DATA_WIDTH-1:1]}; // lsb first
        end
        if ((state == RX_STOP) && bitDone) begin
            rxByte <= shiftReg >> alignShift;
        end
    end

    // ----------------------------------------
    // mid-bit sampler
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= RX_IDLE;
            bitTimer    <= '0;
            bitIndex    <= '0;
            rxByteValid <= 1'b0;
        end else begin
            rxByteValid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bitTimer <= '0;
                    if (!rxIn) state <= RX_START;          // start edge
                end
                RX_START: begin
                    if (halfDone) begin
                        bitTimer <= '0;
                        bitIndex <= '0;
                        // glitch filter, start bit must still be low
                        state    <= rxIn ? RX_IDLE : RX_DATA;
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                RX_DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        if (bitIndex == frameCfg.bitsPerFrame - 4'd1) begin
                            state <= RX_STOP;
                        end else begin
                            bitIndex <= bitIndex + 4'd1;
                        end
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                RX_STOP: begin
                    if (bitDone) begin
                        rxByteValid <= 1'b1;               // middle of stop bit
                        state       <= RX_IDLE;
                    end else begin
                        bitTimer <= bitTimer + 16'd1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/uartTop.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartTop (
    input  logic           clk,
    input  logic           reset,
    input  logic           reqValid,
    input  uartPkg::busReq req,
    output logic           reqReady,
    output logic           rspValid,
    output uartPkg::busRsp rsp,
    input  logic           rspReady,
    output logic           txIrq,
    output logic           rxIrq,
    output logic           tx,
    input  logic           rx
);
    import uartPkg::*;

    uartConfig                   cfg;          // shared line setup
    logic                        txDataValid;
    logic [`UART_DATA_WIDTH-1:0] txByte;
    logic                        txTake;
    logic                        rxByteValid;
    logic [`UART_DATA_WIDTH-1:0] rxByte;
    logic [`UART_DATA_WIDTH-1:0] fifoHead;
    logic                        fifoEmpty;
    logic                        popReq;

    uartRegs registers (
        .clk, .reset, .reqValid, .req, .reqReady, .rspValid, .rsp, .rspReady,
        .cfg, .txDataValid, .txByte, .txTake, .fifoHead, .fifoEmpty, .popReq,
        .txIrq, .rxIrq
    );

    uartTransmitter transmitter (
        .clk, .reset, .cfg, .txDataValid, .txByte, .txTake, .tx
    );

    uartReceiver receiver (
        .clk, .reset, .cfg, .rx, .rxByteValid, .rxByte
    );

    // count only matters inside the fifo for its full test
    uartFifo receiveFifo (
        .clk,
        .reset,
        .writeEn   (rxByteValid),
        .dataIn    (rxByte),
        .readReq   (popReq),
        .dataOut   (fifoHead),
        .wordCount (),
        .empty     (fifoEmpty)
    );

endmodule

`default_nettype wire

/* tests/uartTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "uart_defs.svh"

module uartTb;
    import uartPkg::*;

    localparam int clockPeriod = 8;
    localparam int testDivisor = 8;
    localparam int framesSent  = 15;   // 6 + 5 loopback, 1 rx irq, 3 tx irq
    localparam int watchdogNs  = framesSent * (`UART_RESET_FRAME_BITS + 2) * testDivisor
                                 * clockPeriod * 2 + 10000;
    localparam int pollLimit   = 400;

    logic  clk;
    logic  reset;
    logic  reqValid;
    busReq req;
    logic  reqReady;
    logic  rspValid;
    busRsp rsp;
    logic  rspReady;
    logic  txIrq;
    logic  rxIrq;
    wire   serialLine;                       // tx looped back into rx

    logic [31:0] lfsrState = 32'hc57e_d2e5;
    int          bitCycles;                  // divisor the DUT runs with
    int          frameBits;
    logic        txIreModel;
    logic        rxIreModel;
    int          holdingCount;               // bytes written but not yet on the line
    int          takePulses;                 // expected txIrq from drained holding reg
    int          enablePulses;               // expected txIrq from txIre rising
    int          txIrqCount;
    int          framesQueued;
    int          framesSeen;
    logic [7:0]  txExpected[$];
    logic [7:0]  rxExpected[$];

    initial clk = 1'b0;
    always #(clockPeriod / 2) clk = ~clk;

    uartTop UUT (
        .clk, .reset, .reqValid, .req, .reqReady, .rspValid, .rsp, .rspReady,
        .txIrq, .rxIrq, .tx(serialLine), .rx(serialLine)
    );

    // ----------------------------------------
    // failure reporting and random data
    // ----------------------------------------

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportError(input string msg);
        stopWithFailure($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    task automatic expectEqual(input logic [15:0] got, input logic [15:0] want,
                               input string what);
        assert (got === want) else
            reportError($sformatf("%s is 0x%0h, expected 0x%0h", what, got, want));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic nextLfsrBit();
        logic feedback;
        feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], nextLfsrBit()};  // one step per bit
        end
        return value;
    endfunction

    // ----------------------------------------
    // host bus
    // ----------------------------------------

    task automatic busTransfer(input logic write, input regAddr addr, input logic [15:0] wdata,
                               input int stall, output logic [15:0] rdata);
        int waitCycles;
        @(negedge clk);
        reqValid   = 1'b1;
        req.write  = write;
        req.addr   = addr;
        req.wdata  = wdata;
        rspReady   = 1'b0;                    // held low until the response shows
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!rspValid && waitCycles < pollLimit);
        assert (rspValid) else reportError("no response to a request");
        assert (waitCycles == 1) else
            reportError($sformatf("response came %0d cycles after the request", waitCycles));
        reqValid = 1'b0;
        for (int i = 0; i < stall; i++) begin
            assert (!reqReady) else reportError("reqReady high while a response waits");
            @(negedge clk);
            assert (rspValid) else reportError("response dropped before rspReady");
        end
        rdata    = rsp.rdata;
        rspReady = 1'b1;
        @(negedge clk);
        rspReady = 1'b0;
        assert (!rspValid) else reportError("second response after one request");
    endtask

    task automatic writeReg(input regAddr addr, input logic [15:0] value);
        logic [15:0] answer;
        busTransfer(1'b1, addr, value, 0, answer);
        expectEqual(answer, 16'd0, "write response");
    endtask

    task automatic readReg(input regAddr addr, output logic [15:0] value);
        int stall;
        stall = nextLfsrBit() ? int'(randomBits(2)) + 1 : 0;  // back-pressure now and then
        busTransfer(1'b0, addr, 16'd0, stall, value);
    endtask

    task automatic expectReg(input regAddr addr, input logic [15:0] want, input string what);
        logic [15:0] value;
        readReg(addr, value);
        expectEqual(value, want, what);
    endtask

    task automatic writeDivisor(input logic [15:0] cycles);
        writeReg(ADDR_DIVISOR, cycles);
        bitCycles = cycles;
    endtask

    task automatic writeFrame(input int bits, input logic rxIe, input logic txIe);
        if (txIe && !txIreModel && holdingCount == 0) enablePulses++;  // rise while empty
        writeReg(ADDR_FRAME, 16'({txIe, rxIe, 4'(bits)}));
        frameBits  = bits;
        rxIreModel = rxIe;
        txIreModel = txIe;
    endtask

    // ----------------------------------------
    // serial traffic
    // ----------------------------------------

    task automatic sendByte(input logic [7:0] value);
        logic [15:0] status;
        int          polls;
        polls = 0;
        do begin
            readReg(ADDR_STATUS, status);
            polls++;
        end while (!status[1] && polls < pollLimit);
        assert (status[1]) else reportError("txReady never came back");
        txExpected.push_back(value);
        rxExpected.push_back(value & 8'((1 << frameBits) - 1));  // short frames lose top bits
        holdingCount++;
        framesQueued++;
        writeReg(ADDR_TXDATA, 16'(value));
    endtask

    task automatic receiveByte();
        logic [15:0] status;
        logic [15:0] value;
        int          polls;
        polls = 0;
        do begin
            readReg(ADDR_STATUS, status);
            polls++;
        end while (!status[0] && polls < pollLimit);
        assert (status[0]) else reportError("no byte arrived in the receive FIFO");
        readReg(ADDR_RXDATA, value);
        expectEqual(value, 16'(rxExpected.pop_front()), "RXDATA");
    endtask

    task automatic waitForFrames();
        while (framesSeen < framesQueued) @(negedge clk);   // until every frame is decoded
    endtask

    task automatic waitRxIrq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (rxIrq !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (rxIrq === level) else reportError($sformatf("rxIrq did not go to %0b", level));
    endtask

    task automatic verifyTxIrqCount();
        @(negedge clk);                        // let the last pulse be counted
        assert (txIrqCount == takePulses + enablePulses) else
            reportError($sformatf("%0d txIrq pulses, expected %0d",
                                  txIrqCount, takePulses + enablePulses));
    endtask

    // ----------------------------------------
    // line monitor and checkers
    // ----------------------------------------

    // decodes each frame on tx at bit middles measured from the start edge
    initial begin : lineMonitor
        logic [7:0] sent;
        forever begin
            @(negedge clk);
            if (!reset && serialLine === 1'b0) begin
                assert (txExpected.size() > 0) else reportError("frame on tx with no write");
                sent = txExpected.pop_front();
                holdingCount--;                 // transmitter took the byte
                if (holdingCount == 0 && txIreModel) takePulses++;
                for (int i = 1; i < bitCycles; i++) begin
                    @(negedge clk);
                    assert (serialLine === 1'b0) else reportError("start bit too short");
                end
                repeat (bitCycles / 2) @(negedge clk);
                for (int k = 0; k < frameBits; k++) begin
                    assert (serialLine === sent[k]) else
                        reportError($sformatf("tx bit %0d of 0x%0h is wrong", k, sent));
                    repeat (bitCycles) @(negedge clk);
                end
                assert (serialLine === 1'b1) else reportError("stop bit is not high");
                framesSeen++;
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && txIrq) txIrqCount++;
        if (!reset && !rxIreModel && rxIrq) reportError("rxIrq high with rxIre clear");
    end

    assert property (@(posedge clk) disable iff (reset) (rspValid && !rspReady) |-> !reqReady)
        else reportError("reqReady high while a response waits");

    assert property (@(posedge clk) disable iff (reset) txIrq |=> !txIrq)
        else reportError("txIrq longer than one cycle");

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin : mainSequence
        logic [15:0] value;
        reset          = 1'b1;
        reqValid       = 1'b0;
        req            = '0;
        rspReady       = 1'b0;
        bitCycles      = `UART_RESET_DIVISOR;
        frameBits      = `UART_RESET_FRAME_BITS;
        txIreModel     = 1'b0;
        rxIreModel     = 1'b0;
        holdingCount   = 0;
        takePulses     = 0;
        enablePulses   = 0;
        txIrqCount     = 0;
        framesQueued   = 0;
        framesSeen     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        @(negedge clk);
        assert (serialLine === 1'b1) else reportError("tx not idle high after reset");
        assert (txIrq === 1'b0 && rxIrq === 1'b0) else reportError("interrupt after reset");
        assert (reqReady === 1'b1 && rspValid === 1'b0) else reportError("bus busy after reset");
        expectReg(ADDR_STATUS, 16'h0002, "STATUS after reset");
        expectReg(ADDR_DIVISOR, 16'(`UART_RESET_DIVISOR), "DIVISOR after reset");
        expectReg(ADDR_FRAME, 16'(`UART_RESET_FRAME_BITS), "FRAME after reset");

        // register read back, one with a long held response
        writeDivisor(16'h1234);
        expectReg(ADDR_DIVISOR, 16'h1234, "DIVISOR");
        writeFrame(5, 1'b0, 1'b1);
        expectReg(ADDR_FRAME, 16'h0025, "FRAME");
        busTransfer(1'b0, ADDR_FRAME, 16'd0, 3, value);
        expectEqual(value, 16'h0025, "FRAME under back-pressure");
        writeFrame(8, 1'b0, 1'b0);
        expectReg(ADDR_FRAME, 16'h0008, "FRAME");
        writeDivisor(testDivisor);
        verifyTxIrqCount();

        // 8 bit loopback
        for (int i = 0; i < 6; i++) begin
            sendByte(8'(randomBits(8)));
            if (i == 1) expectReg(ADDR_STATUS, 16'h0000, "STATUS with byte pending");
        end
        for (int i = 0; i < 6; i++) receiveByte();
        expectReg(ADDR_STATUS, 16'h0002, "STATUS after draining");

        // 5 bit loopback
        writeFrame(5, 1'b0, 1'b0);
        for (int i = 0; i < 5; i++) sendByte(8'(randomBits(8)));
        for (int i = 0; i < 5; i++) receiveByte();
        expectReg(ADDR_STATUS, 16'h0002, "STATUS after 5 bit frames");
        writeFrame(8, 1'b0, 1'b0);
        verifyTxIrqCount();

        // receive interrupt level
        writeFrame(8, 1'b1, 1'b0);
        sendByte(8'(randomBits(8)));
        assert (rxIrq === 1'b0) else reportError("rxIrq high before a byte arrived");
        waitRxIrq(1'b1, bitCycles * (frameBits + 2) * 2);
        receiveByte();
        waitRxIrq(1'b0, 4);
        writeFrame(8, 1'b0, 1'b0);

        // transmit interrupt pulses
        waitForFrames();
        writeFrame(8, 1'b0, 1'b1);
        verifyTxIrqCount();
        for (int i = 0; i < 3; i++) sendByte(8'(randomBits(8)));
        waitForFrames();
        for (int i = 0; i < 3; i++) receiveByte();
        verifyTxIrqCount();
        writeFrame(8, 1'b0, 1'b0);

        $display("RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        #(watchdogNs);
        stopWithFailure("Timeout, the tests did not finish in the expected time");
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/uartPkg.sv
src/uartFifo.sv
src/uartRegs.sv
src/uartTransmitter.sv
src/uartReceiver.sv
src/uartTop.sv
tests/uartTb.sv
